/* compile.f */
+incdir+.
lc3b_pkg.sv
lc3b_regfile.sv
lc3b_decode.sv
lc3b_execute.sv
lc3b_mem_wb.sv
lc3b_pipeline.sv
tb_lc3b_checker.sv
tb_lc3b.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_lc3b -f compile.f -o tb_lc3b_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_lc3b_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" "$LOG"; then
	echo "FAIL"
	exit 1
fi

echo "PASS"
exit 0

/* tb_lc3b.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lc3b;

	localparam int NUM_INSTR  = 400;
	localparam int MAX_CYCLES = 4 * NUM_INSTR + 100;

	logic                clk = 1'b0;
	logic                rst_n;
	lc3b_pkg::lc3b_instr instr;
	logic                instr_valid;
	logic                instr_ready;
	lc3b_pkg::lc3b_wb    wb;
	logic [2:0]          cc;
	logic                end_of_test;
	int                  errors;
	int                  wb_count;
	int                  cc_count;
	integer              seed;
	int                  cycles = 0;
	int                  issued;

	always #10 clk = ~clk;

	lc3b_pipeline dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.wb          (wb),
		.cc          (cc)
	);

	tb_lc3b_checker checker_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.wb          (wb),
		.cc          (cc),
		.end_of_test (end_of_test),
		.errors      (errors),
		.wb_count    (wb_count),
		.cc_count    (cc_count)
	);

	// ********************
	// Random instructions.
	// ********************
	// R7 is never a destination, so it stays a zero base and loads hit earlier stores.
	function automatic lc3b_pkg::lc3b_word random_instr();
		logic [31:0]        r;
		logic [2:0]         dr;
		logic [2:0]         sa;
		logic [2:0]         sb;
		logic [2:0]         base;
		lc3b_pkg::lc3b_word w;
		r = $random(seed);
		dr = 3'(r[15:8] % 7);
		sa = r[18:16];
		sb = r[21:19];
		base = (r[23:22] != 2'b00) ? 3'd7 : r[26:24];
		case (r[30:28])
			3'd0:       w = {lc3b_pkg::op_add, dr, sa, 3'b000, sb};
			3'd1, 3'd7: w = {lc3b_pkg::op_add, dr, sa, 1'b1, r[4:0]};
			3'd2:       w = {lc3b_pkg::op_and, dr, sa, 3'b000, sb};
			3'd3:       w = {lc3b_pkg::op_and, dr, sa, 1'b1, r[4:0]};
			3'd4:       w = {lc3b_pkg::op_not, dr, sa, 6'h3f};
			3'd5:       w = {lc3b_pkg::op_ldr, dr, base, r[5:0]};
			default:    w = {lc3b_pkg::op_str, sa, base, r[5:0]};
		endcase
		return w;
	endfunction

	initial begin
		seed = 32'hf7cd_e055;
		rst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		end_of_test = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (issued = 0; issued < NUM_INSTR; issued++) begin
			@(posedge clk);
			instr <= random_instr();
			instr_valid <= 1'b1;
			@(negedge clk);
			while (!instr_ready)
				@(negedge clk);      // Held through a stall.
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		repeat (4) @(posedge clk);      // Pipeline is three deep.
		end_of_test <= 1'b1;
		repeat (2) @(posedge clk);
		$display("Write-backs %0d, cc samples %0d, errors %0d", wb_count, cc_count, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Write-backs %0d, cc samples %0d, errors %0d", wb_count, cc_count, errors);
			$display("Errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb_lc3b_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_params.svh"

module tb_lc3b_checker (
	input  logic                clk,
	input  logic                rst_n,
	input  lc3b_pkg::lc3b_instr instr,
	input  logic                instr_valid,
	input  logic                instr_ready,
	input  lc3b_pkg::lc3b_wb    wb,
	input  logic [2:0]          cc,
	input  logic                end_of_test,
	output int                  errors,
	output int                  wb_count,
	output int                  cc_count
);

	lc3b_pkg::lc3b_word pending [$];      // Accepted, not yet retired.
	lc3b_pkg::lc3b_word regs [`LC3B_NUM_REGS];
	lc3b_pkg::lc3b_word dmem [`LC3B_DMEM_WORDS];
	logic [2:0]         cc_model;
	logic               drained;
	lc3b_pkg::lc3b_word ahead;            // Instruction now in decode output.
	logic               ahead_valid;
	logic               ready_exp;

	// ********************
	// Architectural model.
	// ********************
	function automatic logic [2:0] flags_of(input lc3b_pkg::lc3b_word v);
		if (v[`LC3B_WORD_W-1])
			return 3'b100;
		if (v == '0)
			return 3'b010;
		return 3'b001;
	endfunction

	// Base register plus offset6 scaled to bytes.
	function automatic lc3b_pkg::lc3b_word mem_addr(input lc3b_pkg::lc3b_word w);
		return regs[w[8:6]] + {{9{w[5]}}, w[5:0], 1'b0};
	endfunction

	function automatic int mem_index(input lc3b_pkg::lc3b_word addr);
		return int'(addr >> 1) % `LC3B_DMEM_WORDS;
	endfunction

	function automatic lc3b_pkg::lc3b_word result_of(input lc3b_pkg::lc3b_word w);
		lc3b_pkg::lc3b_word b;
		b = w[5] ? {{11{w[4]}}, w[4:0]} : regs[w[2:0]];
		case (w[15:12])
			lc3b_pkg::op_add: return regs[w[8:6]] + b;
			lc3b_pkg::op_and: return regs[w[8:6]] & b;
			lc3b_pkg::op_not: return ~regs[w[8:6]];
			default:          return dmem[mem_index(mem_addr(w))];     // LDR.
		endcase
	endfunction

	// RAW dependence of w on the register-writing instruction just ahead.
	function automatic logic depends_on(input lc3b_pkg::lc3b_word prev,
	                                    input lc3b_pkg::lc3b_word w);
		logic [2:0] dest;
		dest = prev[11:9];
		if (prev[15:12] == lc3b_pkg::op_str)
			return 1'b0;
		if (w[8:6] == dest)
			return 1'b1;
		if (w[15:12] == lc3b_pkg::op_str)
			return w[11:9] == dest;
		if ((w[15:12] == lc3b_pkg::op_add || w[15:12] == lc3b_pkg::op_and) && !w[5])
			return w[2:0] == dest;
		return 1'b0;
	endfunction

	task automatic reset_model();
		for (int i = 0; i < `LC3B_NUM_REGS; i++)
			regs[i] = '0;
		for (int i = 0; i < `LC3B_DMEM_WORDS; i++)
			dmem[i] = '0;
		cc_model = 3'b010;
		pending.delete();
		drained = 1'b0;
		ahead = '0;
		ahead_valid = 1'b0;
	endtask

	task automatic check_writeback();
		lc3b_pkg::lc3b_word w;
		lc3b_pkg::lc3b_word expected;
		logic               found;
		found = 1'b0;
		w = '0;
		while (!found && pending.size() > 0) begin
			w = pending.pop_front();
			if (w[15:12] == lc3b_pkg::op_str)
				dmem[mem_index(mem_addr(w))] = regs[w[11:9]];     // No write-back.
			else
				found = 1'b1;
		end
		if (!found) begin
			$display("Write-back to R%0d arrived with no instruction waiting for it", wb.dest);
			errors++;
		end else begin
			expected = result_of(w);
			if (wb.dest !== w[11:9]) begin
				$display("[ERROR] wb.dest expected %h actual %h", w[11:9], wb.dest);
				errors++;
			end
			if (wb.data !== expected) begin
				$display("[ERROR] wb.data expected %h actual %h", expected, wb.data);
				errors++;
			end
			regs[w[11:9]] = expected;
			cc_model = flags_of(expected);
			wb_count++;
		end
	endtask

	task automatic drain();
		lc3b_pkg::lc3b_word w;
		while (pending.size() > 0) begin
			w = pending.pop_front();
			if (w[15:12] != lc3b_pkg::op_str) begin
				$display("Missing write-back for instruction %h", w);
				errors++;
			end
		end
		drained = 1'b1;
	endtask

	// ********************
	// Comparison.
	// ********************
	// Sampled mid-cycle, where every DUT output is settled.
	always @(negedge clk) begin
		if (!rst_n) begin
			reset_model();
			if (instr_ready !== 1'b0) begin
				$display("[ERROR] instr_ready expected %h actual %h", 1'b0, instr_ready);
				errors++;
			end
		end else begin
			if (cc !== cc_model) begin      // DUT cc trails the model by one edge.
				$display("[ERROR] cc expected %h actual %h", cc_model, cc);
				errors++;
			end
			cc_count++;
			if (wb.valid !== 1'b0)
				check_writeback();
			if (instr_valid) begin
				ready_exp = !(ahead_valid && depends_on(ahead, instr));
				if (instr_ready !== ready_exp) begin
					$display("[ERROR] instr_ready expected %h actual %h", ready_exp, instr_ready);
					errors++;
				end
			end
			if (instr_valid && instr_ready)
				pending.push_back(instr);     // Taken at the next rising edge.
			ahead_valid = instr_valid && instr_ready;
			ahead = instr;
			if (end_of_test && !drained)
				drain();
		end
	end

endmodule

`default_nettype wire

/* lc3b_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_pipeline (
	input  logic                clk,
	input  logic                rst_n,
	input  lc3b_pkg::lc3b_instr instr,
	input  logic                instr_valid,
	output logic                instr_ready,
	output lc3b_pkg::lc3b_wb    wb,
	output logic [2:0]          cc
);

	lc3b_pkg::lc3b_id_ex id_ex;
	lc3b_pkg::lc3b_ex_mw ex_mw;

	// ********************
	// Stages.
	// ********************
	lc3b_decode decode_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.wb          (wb),          // Register file write.
		.id_ex       (id_ex)
	);

	lc3b_execute execute_i (
		.clk   (clk),
		.rst_n (rst_n),
		.id_ex (id_ex),
		.ex_mw (ex_mw)
	);

	lc3b_mem_wb mem_wb_i (
		.clk   (clk),
		.rst_n (rst_n),
		.ex_mw (ex_mw),
		.wb    (wb),
		.cc    (cc)
	);

endmodule

`default_nettype wire

/* lc3b_mem_wb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_params.svh"

module lc3b_mem_wb (
	input  logic                clk,
	input  logic                rst_n,
	input  lc3b_pkg::lc3b_ex_mw ex_mw,
	output lc3b_pkg::lc3b_wb    wb,
	output logic [2:0]          cc
);

	localparam int DMEM_AW = $clog2(`LC3B_DMEM_WORDS);

	lc3b_pkg::lc3b_word dmem [`LC3B_DMEM_WORDS];
	logic [DMEM_AW-1:0] dmem_addr;
	lc3b_pkg::lc3b_word load_data;
	logic               cc_n;
	logic               cc_z;

	initial begin
		for (int i = 0; i < `LC3B_DMEM_WORDS; i++)
			dmem[i] = '0;
	end

	// Word address, wraps at the memory depth.
	assign dmem_addr = ex_mw.result[DMEM_AW:1];

	// ********************
	// Data memory.
	// ********************
	always_ff @(posedge clk) begin
		if (ex_mw.valid && ex_mw.ctrl.mem_write)
			dmem[dmem_addr] <= ex_mw.store_data;
	end

	assign load_data = dmem[dmem_addr];

	// Write-back port.
	assign wb.valid = ex_mw.valid && ex_mw.ctrl.load_regfile;
	assign wb.dest  = ex_mw.dest;
	assign wb.data  = ex_mw.ctrl.mem_read ? load_data : ex_mw.result;

	assign cc_n = wb.data[`LC3B_WORD_W-1];
	assign cc_z = (wb.data == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cc <= 3'b010;      // z after reset.
		end else if (ex_mw.valid && ex_mw.ctrl.load_cc) begin
			cc <= {cc_n, cc_z, !cc_n && !cc_z};
		end
	end

	a_rd_wr_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		ex_mw.valid |-> !(ex_mw.ctrl.mem_read && ex_mw.ctrl.mem_write)
	) else $error("bundle has both mem_read and mem_write");

endmodule

`default_nettype wire

/* lc3b_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_execute (
	input  logic                clk,
	input  logic                rst_n,
	input  lc3b_pkg::lc3b_id_ex id_ex,
	output lc3b_pkg::lc3b_ex_mw ex_mw
);

	lc3b_pkg::lc3b_word opnd_b;
	lc3b_pkg::lc3b_word alu_out;

	// Immediate path covers both imm5 and offset forms.
	assign opnd_b = (id_ex.ctrl.srcb_sel == lc3b_pkg::srcb_reg) ? id_ex.srcb : id_ex.imm;

	// ********************
	// ALU.
	// ********************
	always_comb begin
		case (id_ex.ctrl.aluop)
			lc3b_pkg::alu_add: alu_out = id_ex.srca + opnd_b;
			lc3b_pkg::alu_and: alu_out = id_ex.srca & opnd_b;
			lc3b_pkg::alu_not: alu_out = ~id_ex.srca;
			default:           alu_out = opnd_b;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mw <= '0;
		end else begin
			ex_mw.valid      <= id_ex.valid;
			ex_mw.ctrl       <= id_ex.ctrl;
			ex_mw.dest       <= id_ex.dest;
			ex_mw.result     <= alu_out;      // Address for LDR and STR.
			ex_mw.store_data <= id_ex.store_data;
		end
	end

	// A bubble entering execute never turns into a memory or register write.
	a_bubble_quiet: assert property (
		@(posedge clk) disable iff (!rst_n)
		!id_ex.valid |=> !(ex_mw.ctrl.load_regfile || ex_mw.ctrl.mem_write) || ex_mw.valid
	) else $error("bubble carries write control");

endmodule

`default_nettype wire

/* lc3b_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_params.svh"

module lc3b_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  lc3b_pkg::lc3b_instr instr,
	input  logic                instr_valid,
	output logic                instr_ready,
	input  lc3b_pkg::lc3b_wb    wb,
	output lc3b_pkg::lc3b_id_ex id_ex
);

	lc3b_pkg::lc3b_opcode opcode;
	lc3b_pkg::lc3b_reg    src_a;
	lc3b_pkg::lc3b_reg    src_b;
	lc3b_pkg::lc3b_word   reg_a;
	lc3b_pkg::lc3b_word   reg_b;
	lc3b_pkg::lc3b_word   imm;
	lc3b_pkg::lc3b_ctrl   ctrl;
	logic                 op_ok;
	logic                 uses_b;
	logic                 hazard;
	logic                 run_q;
	logic                 accept;

	assign opcode = instr.op.opcode;
	assign src_a  = instr.op.sr1;      // Same bits as the base register.
	assign src_b  = (opcode == lc3b_pkg::op_str) ? instr.mem.dr_sr : instr.op.sr2_imm5[2:0];

	lc3b_regfile regfile_i (
		.clk   (clk),
		.rst_n (rst_n),
		.wb    (wb),
		.src_a (src_a),
		.src_b (src_b),
		.reg_a (reg_a),
		.reg_b (reg_b)
	);

	// ********************
	// Control generation.
	// ********************
	always_comb begin
		ctrl = '{aluop: lc3b_pkg::alu_pass, srcb_sel: lc3b_pkg::srcb_reg, default: 1'b0};
		op_ok = 1'b1;
		case (opcode)
			lc3b_pkg::op_add, lc3b_pkg::op_and: begin
				ctrl.aluop = (opcode == lc3b_pkg::op_add) ? lc3b_pkg::alu_add : lc3b_pkg::alu_and;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				if (instr.op.imm_flag)
					ctrl.srcb_sel = lc3b_pkg::srcb_imm5;
			end
			lc3b_pkg::op_not: begin
				ctrl.aluop = lc3b_pkg::alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			lc3b_pkg::op_ldr: begin
				ctrl.aluop = lc3b_pkg::alu_add;
				ctrl.srcb_sel = lc3b_pkg::srcb_offset;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.mem_read = 1'b1;
			end
			lc3b_pkg::op_str: begin
				ctrl.aluop = lc3b_pkg::alu_add;
				ctrl.srcb_sel = lc3b_pkg::srcb_offset;
				ctrl.mem_write = 1'b1;
			end
			default: op_ok = 1'b0;
		endcase
	end

	always_comb begin
		case (ctrl.srcb_sel)
			lc3b_pkg::srcb_imm5:
				imm = {{(`LC3B_WORD_W-5){instr.op.sr2_imm5[4]}}, instr.op.sr2_imm5};
			lc3b_pkg::srcb_offset:
				imm = {{(`LC3B_WORD_W-7){instr.mem.offset6[5]}}, instr.mem.offset6, 1'b0};
			default:
				imm = '0;
		endcase
	end

	// RAW check against the instruction one stage ahead.
	assign uses_b = (ctrl.srcb_sel == lc3b_pkg::srcb_reg && opcode != lc3b_pkg::op_not) ||
	                ctrl.mem_write;
	assign hazard = id_ex.valid && id_ex.ctrl.load_regfile &&
	                (id_ex.dest == src_a || (uses_b && id_ex.dest == src_b));

	assign instr_ready = run_q && !hazard;
	assign accept      = instr_valid && instr_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_q <= 1'b0;
			id_ex <= '0;
		end else begin
			run_q <= 1'b1;
			id_ex.valid      <= accept;     // Bubble on stall.
			id_ex.ctrl       <= accept ? ctrl : '0;
			id_ex.dest       <= instr.op.dr;
			id_ex.srca       <= reg_a;
			id_ex.srcb       <= reg_b;
			id_ex.store_data <= reg_b;
			id_ex.imm        <= imm;
		end
	end

	a_supported_op: assert property (
		@(posedge clk) disable iff (!rst_n)
		accept |-> op_ok
	) else $error("unsupported opcode %b accepted", opcode);

endmodule

`default_nettype wire

/* lc3b_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_params.svh"

module lc3b_regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  lc3b_pkg::lc3b_wb   wb,
	input  lc3b_pkg::lc3b_reg  src_a,
	input  lc3b_pkg::lc3b_reg  src_b,
	output lc3b_pkg::lc3b_word reg_a,
	output lc3b_pkg::lc3b_word reg_b
);

	lc3b_pkg::lc3b_word regs [`LC3B_NUM_REGS];

	// Same-cycle write is visible to the reader.
	function automatic lc3b_pkg::lc3b_word read_port(input lc3b_pkg::lc3b_reg src);
		if (wb.valid && wb.dest == src)
			return wb.data;
		return regs[src];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb.valid) begin
			regs[wb.dest] <= wb.data;
		end
	end

	always_comb begin
		reg_a = read_port(src_a);
		reg_b = read_port(src_b);
	end

endmodule

`default_nettype wire

/* lc3b_pkg.sv */
`default_nettype none

`include "lc3b_params.svh"

package lc3b_pkg;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;

	typedef enum logic [3:0] {
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001,
		op_ldr = 4'b0110,
		op_str = 4'b0111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_aluop;

	typedef enum logic [1:0] {
		srcb_reg,
		srcb_imm5,
		srcb_offset
	} lc3b_srcb_sel;

	// ********************
	// Instruction word views.
	// ********************
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg    dr;
		lc3b_reg    sr1;
		logic       imm_flag;
		logic [4:0] sr2_imm5;      // sr2 in [2:0] when imm_flag is clear.
	} lc3b_op_fmt;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg    dr_sr;
		lc3b_reg    base;
		logic [5:0] offset6;
	} lc3b_mem_fmt;

	typedef union packed {
		lc3b_op_fmt  op;
		lc3b_mem_fmt mem;
	} lc3b_instr;

	typedef struct packed {
		lc3b_aluop    aluop;
		lc3b_srcb_sel srcb_sel;
		logic         load_regfile;
		logic         load_cc;
		logic         mem_read;
		logic         mem_write;
	} lc3b_ctrl;

	typedef struct packed {
		logic     valid;
		lc3b_ctrl ctrl;
		lc3b_reg  dest;
		lc3b_word srca;
		lc3b_word srcb;
		lc3b_word store_data;
		lc3b_word imm;         // Already sign-extended.
	} lc3b_id_ex;

	typedef struct packed {
		logic     valid;
		lc3b_ctrl ctrl;
		lc3b_reg  dest;
		lc3b_word result;      // ALU result or memory address.
		lc3b_word store_data;
	} lc3b_ex_mw;

	typedef struct packed {
		logic     valid;
		lc3b_reg  dest;
		lc3b_word data;
	} lc3b_wb;

endpackage

`default_nettype wire

/* lc3b_params.svh */
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// ********************
// Datapath sizing.
// ********************

// Width of one machine word.
`define LC3B_WORD_W 16

// Architectural register count.
`define LC3B_NUM_REGS 8

// Data memory depth in words.
`define LC3B_DMEM_WORDS 256

`endif
